//--- src/cpu_pkg.sv
package cpu_pkg;

    // cp0 register numbers, sel 0
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_COUNT    = 5'd9;
    localparam logic [4:0] CP0_COMPARE  = 5'd11;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    localparam logic [4:0] EXC_INT  = 5'h00;
    localparam logic [4:0] EXC_ADEL = 5'h04;  // load or fetch address error
    localparam logic [4:0] EXC_ADES = 5'h05;  // store address error
    localparam logic [4:0] EXC_SYS  = 5'h08;
    localparam logic [4:0] EXC_OV   = 5'h0c;

    localparam logic [31:0] EXC_VECTOR      = 32'hbfc0_0380;  // bev=1 general vector
    localparam logic [19:0] MAP_USEG_OFFSET = 20'h20000;      // in 4 KB frames

    // access size, shared by pipeline bus and cache request
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] rt_value;       // mtc0 source
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic        mem_we;
        logic [3:0]  wstrb;
        logic [31:0] wdata;          // store data, already lane aligned
        logic [1:0]  mem_size;
        logic        load_unsigned;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        inst_eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        ex;
        logic [4:0]  exccode;
        logic        bd;
    } es_to_m1_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] final_result;
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic [1:0]  mem_size;
        logic        load_unsigned;
        logic [1:0]  byte_offset;
        logic        ex;
    } m1_to_ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] wdata;
    } ws_bus_t;

    typedef struct packed {
        logic        op;             // 1 = store
        logic [7:0]  index;
        logic [19:0] tag;            // physical frame
        logic [3:0]  offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [1:0]  size;
        logic        uncached;
    } dcache_req_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [7:0]  index;
        logic [3:0]  offset;
    } vaddr_fields_t;

    typedef union packed {
        logic [31:0]   word;
        vaddr_fields_t f;
    } vaddr_u;

endpackage

//--- src/cp0_regs.sv
module cp0_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        valid,
    input  logic        commit,       // instruction leaves m1 this edge
    input  logic [4:0]  cp0_rd,
    input  logic [2:0]  cp0_sel,
    input  logic        inst_mtc0,
    input  logic        inst_eret,
    input  logic        ex,
    input  logic [4:0]  exccode,
    input  logic        bd,
    input  logic [31:0] pc,
    input  logic [31:0] badvaddr,
    input  logic [31:0] wdata,
    input  logic [5:0]  ext_int,
    output logic [31:0] rdata,
    output logic [31:0] epc,
    output logic        int_pending
);
    import cpu_pkg::*;

    logic        wr_en;
    logic        ex_commit;
    logic        eret_commit;
    logic        mtc0_commit;
    logic [7:0]  status_im;
    logic        status_exl;
    logic        status_ie;
    logic        cause_bd;
    logic        cause_ti;
    logic [1:0]  cause_ip_sw;
    logic [4:0]  cause_exccode;
    logic [5:0]  ext_int_q;
    logic [7:0]  cause_ip;
    logic        tick;
    logic [31:0] count_r;
    logic [31:0] compare_r;
    logic [31:0] epc_r;
    logic [31:0] badvaddr_r;

    assign wr_en       = valid & commit;
    assign ex_commit   = wr_en & ex;
    assign eret_commit = wr_en & inst_eret;
    assign mtc0_commit = wr_en & inst_mtc0 & (cp0_sel == 3'd0);

    // ip7 shared between hw int 5 and the timer
    assign cause_ip = {ext_int_q[5] | cause_ti, ext_int_q[4:0], cause_ip_sw};

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= 8'h00;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (ex_commit) begin
            status_exl <= 1'b1;
        end else if (eret_commit) begin
            status_exl <= 1'b0;
        end else if (mtc0_commit && cp0_rd == CP0_STATUS) begin
            status_im  <= wdata[15:8];
            status_exl <= wdata[1];
            status_ie  <= wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd      <= 1'b0;
            cause_exccode <= 5'd0;
            cause_ip_sw   <= 2'b00;
        end else if (ex_commit) begin
            if (!status_exl) cause_bd <= bd;  // nested exception keeps old bd
            cause_exccode <= exccode;
        end else if (mtc0_commit && cp0_rd == CP0_CAUSE) begin
            cause_ip_sw <= wdata[9:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ext_int_q <= 6'd0;
            tick      <= 1'b0;
            count_r   <= 32'd0;
            compare_r <= 32'hffff_ffff;
            cause_ti  <= 1'b0;
        end else begin
            ext_int_q <= ext_int;
            tick      <= ~tick;
            if (mtc0_commit && cp0_rd == CP0_COUNT) count_r <= wdata;
            else if (tick) count_r <= count_r + 32'd1;  // half clock rate
            if (mtc0_commit && cp0_rd == CP0_COMPARE) begin
                compare_r <= wdata;
                cause_ti  <= 1'b0;  // compare write acks the timer
            end else if (count_r == compare_r) begin
                cause_ti <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_commit && !status_exl) epc_r <= bd ? pc - 32'd4 : pc;
        else if (mtc0_commit && cp0_rd == CP0_EPC) epc_r <= wdata;
        if (ex_commit && (exccode == EXC_ADEL || exccode == EXC_ADES)) badvaddr_r <= badvaddr;
    end

    always_comb begin
        rdata = 32'd0;
        if (cp0_sel == 3'd0) begin
            case (cp0_rd)
                CP0_BADVADDR: rdata = badvaddr_r;
                CP0_COUNT:    rdata = count_r;
                CP0_COMPARE:  rdata = compare_r;
                CP0_STATUS:   rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
                CP0_CAUSE:    rdata = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0,
                                       cause_exccode, 2'b00};
                CP0_EPC:      rdata = epc_r;
                default:      rdata = 32'd0;
            endcase
        end
    end

    assign epc         = epc_r;
    assign int_pending = status_ie & ~status_exl & (|(cause_ip & status_im));

    // execute must never tag an mtc0 with an exception
    assert property (@(posedge clk) disable iff (reset) wr_en |-> !(inst_mtc0 && ex));

endmodule

//--- src/dtlb_map.sv
module dtlb_map (
    input  logic [19:0] vpn,
    output logic [19:0] pfn,
    output logic        uncached
);
    import cpu_pkg::*;

    always_comb begin
        pfn      = vpn;    // kseg2/kseg3 pass straight through
        uncached = 1'b0;
        case (vpn[19:17])
            3'b100: begin  // kseg0
                pfn = {3'b000, vpn[16:0]};
            end
            3'b101: begin  // kseg1, same frame as kseg0
                pfn      = {3'b000, vpn[16:0]};
                uncached = 1'b1;
            end
            3'b110,
            3'b111: begin
                pfn = vpn;
            end
            default: begin  // useg
                pfn = vpn + MAP_USEG_OFFSET;
            end
        endcase
    end

endmodule

//--- src/m1_stage.sv
module m1_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  es_valid,
    input  cpu_pkg::es_to_m1_t    es_bus,
    output logic                  m1_allowin,
    output logic                  m1s_to_ms_valid,
    output cpu_pkg::m1_to_ms_t    m1s_to_ms_bus,
    input  logic                  ms_allowin,
    output logic [4:0]            fwd_dest,
    output logic [31:0]           fwd_result,
    output logic                  fwd_load_op,
    output logic                  fwd_mfc0,
    output logic                  flush,
    output logic [31:0]           flush_target,
    input  logic [5:0]            ext_int,
    output logic                  dcache_valid,
    output cpu_pkg::dcache_req_t  dcache_req,
    input  logic                  dcache_busy
);
    import cpu_pkg::*;

    es_to_m1_t   m1_r;
    logic        m1_valid;
    logic        m1_ready_go;
    logic        mem_op;
    logic        int_pending;
    logic        int_take;
    logic        m1_ex;
    logic [4:0]  m1_exccode;
    logic [31:0] cp0_rdata;
    logic [31:0] cp0_epc;
    logic [31:0] final_result;
    logic [19:0] pfn;
    logic        uncached;
    vaddr_u      va;

    assign mem_op      = m1_r.load_op | m1_r.mem_we;
    assign int_take    = m1_valid & int_pending;  // interrupt lands on the m1 instruction
    assign m1_ex       = m1_r.ex | int_take;
    assign m1_exccode  = m1_r.ex ? m1_r.exccode : EXC_INT;
    assign m1_ready_go = m1_ex | ~mem_op | ~dcache_busy;
    assign m1_allowin  = ~m1_valid | (m1_ready_go & ms_allowin);
    assign m1s_to_ms_valid = m1_valid & m1_ready_go;

    always_ff @(posedge clk) begin
        if (reset) m1_valid <= 1'b0;
        else if (m1_allowin) m1_valid <= es_valid & ~flush;  // younger work dropped on flush
    end

    always_ff @(posedge clk) begin
        if (es_valid && m1_allowin) m1_r <= es_bus;
    end

    cp0_regs cp0_i (
        .clk(clk), .reset(reset), .valid(m1_valid), .commit(m1_ready_go & ms_allowin),
        .cp0_rd(m1_r.cp0_rd), .cp0_sel(m1_r.cp0_sel),
        .inst_mtc0(m1_r.inst_mtc0 & ~int_take), .inst_eret(m1_r.inst_eret & ~m1_ex),
        .ex(m1_ex), .exccode(m1_exccode), .bd(m1_r.bd), .pc(m1_r.pc),
        .badvaddr(va.word), .wdata(m1_r.rt_value), .ext_int(ext_int),
        .rdata(cp0_rdata), .epc(cp0_epc), .int_pending(int_pending)
    );

    assign va.word = m1_r.alu_result;

    dtlb_map dtlb_i (.vpn(va.f.vpn), .pfn(pfn), .uncached(uncached));

    assign final_result = m1_r.inst_mfc0 ? cp0_rdata : m1_r.alu_result;
    assign fwd_dest     = m1_r.dest & {5{m1_valid}};
    assign fwd_result   = final_result;
    assign fwd_load_op  = m1_valid & m1_r.load_op;
    assign fwd_mfc0     = m1_valid & m1_r.inst_mfc0;

    assign flush        = m1_valid & (m1_ex | m1_r.inst_eret);
    assign flush_target = m1_ex ? EXC_VECTOR : cp0_epc;

    // issued only in the cycle the instruction leaves, so never twice
    assign dcache_valid = m1_valid & mem_op & ~m1_ex & ~m1_r.inst_eret & ~dcache_busy
                        & ms_allowin;

    always_comb begin
        dcache_req.op       = m1_r.mem_we;
        dcache_req.index    = va.f.index;
        dcache_req.tag      = pfn;
        dcache_req.offset   = va.f.offset;
        dcache_req.wstrb    = m1_r.mem_we ? m1_r.wstrb : 4'h0;
        dcache_req.wdata    = m1_r.wdata;
        dcache_req.size     = m1_r.mem_size;
        dcache_req.uncached = uncached;
    end

    always_comb begin
        m1s_to_ms_bus.pc            = m1_r.pc;
        m1s_to_ms_bus.final_result  = final_result;
        m1s_to_ms_bus.dest          = m1_r.dest;
        m1s_to_ms_bus.gr_we         = m1_r.gr_we;
        m1s_to_ms_bus.load_op       = m1_r.load_op;
        m1s_to_ms_bus.mem_size      = m1_r.mem_size;
        m1s_to_ms_bus.load_unsigned = m1_r.load_unsigned;
        m1s_to_ms_bus.byte_offset   = va.f.offset[1:0];
        m1s_to_ms_bus.ex            = m1_ex;
    end

    // after a request m1 is empty or holds a newly accepted instruction
    assert property (@(posedge clk) disable iff (reset)
        dcache_valid |=> !m1_valid || $past(es_valid && m1_allowin));

endmodule

//--- src/ms_stage.sv
module ms_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               m1s_to_ms_valid,
    input  cpu_pkg::m1_to_ms_t m1s_to_ms_bus,
    output logic               ms_allowin,
    input  logic [31:0]        dcache_rdata,
    output logic               ws_valid,
    output cpu_pkg::ws_bus_t   ws_bus,
    input  logic               ws_allowin
);
    import cpu_pkg::*;

    m1_to_ms_t   ms_r;
    logic        ms_valid;
    logic        fresh;       // first cycle in ms, cache data on the bus
    logic [31:0] rdata_q;
    logic [31:0] rdata;
    logic [31:0] shifted;
    logic [31:0] load_value;

    assign ms_allowin = ~ms_valid | ws_allowin;
    assign ws_valid   = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
            fresh    <= 1'b0;
        end else begin
            if (ms_allowin) ms_valid <= m1s_to_ms_valid;
            fresh <= m1s_to_ms_valid & ms_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (m1s_to_ms_valid && ms_allowin) ms_r <= m1s_to_ms_bus;
        if (fresh) rdata_q <= dcache_rdata;  // keep data while ws stalls
    end

    assign rdata   = fresh ? dcache_rdata : rdata_q;
    assign shifted = rdata >> {ms_r.byte_offset, 3'b000};

    always_comb begin
        case (ms_r.mem_size)
            SIZE_BYTE: load_value = {{24{~ms_r.load_unsigned & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: load_value = {{16{~ms_r.load_unsigned & shifted[15]}}, shifted[15:0]};
            default:   load_value = rdata;
        endcase
    end

    assign ws_bus.pc    = ms_r.pc;
    assign ws_bus.dest  = ms_r.dest;
    assign ws_bus.gr_we = ms_r.gr_we & ~ms_r.ex;  // flushed instruction writes nothing
    assign ws_bus.wdata = ms_r.load_op ? load_value : ms_r.final_result;

    assert property (@(posedge clk) disable iff (reset)
        (ws_valid && ws_allowin && ms_r.load_op && !ms_r.ex) |->
            (ms_r.mem_size == SIZE_BYTE || ms_r.byte_offset == 2'b00 ||
             (ms_r.mem_size == SIZE_HALF && !ms_r.byte_offset[0])));

endmodule

//--- src/cpu_mem1.sv
module cpu_mem1 (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  es_valid,
    input  cpu_pkg::es_to_m1_t    es_bus,
    output logic                  m1_allowin,
    output logic [4:0]            fwd_dest,
    output logic [31:0]           fwd_result,
    output logic                  fwd_load_op,
    output logic                  fwd_mfc0,
    output logic                  flush,
    output logic [31:0]           flush_target,
    input  logic [5:0]            ext_int,
    output logic                  dcache_valid,
    output cpu_pkg::dcache_req_t  dcache_req,
    input  logic                  dcache_busy,
    input  logic [31:0]           dcache_rdata,
    output logic                  ws_valid,
    output cpu_pkg::ws_bus_t      ws_bus,
    input  logic                  ws_allowin
);
    import cpu_pkg::*;

    logic      m1s_to_ms_valid;
    m1_to_ms_t m1s_to_ms_bus;
    logic      ms_allowin;

    m1_stage m1_i (
        .clk(clk), .reset(reset), .es_valid(es_valid), .es_bus(es_bus),
        .m1_allowin(m1_allowin), .m1s_to_ms_valid(m1s_to_ms_valid),
        .m1s_to_ms_bus(m1s_to_ms_bus), .ms_allowin(ms_allowin),
        .fwd_dest(fwd_dest), .fwd_result(fwd_result), .fwd_load_op(fwd_load_op),
        .fwd_mfc0(fwd_mfc0), .flush(flush), .flush_target(flush_target), .ext_int(ext_int),
        .dcache_valid(dcache_valid), .dcache_req(dcache_req), .dcache_busy(dcache_busy)
    );

    ms_stage ms_i (
        .clk(clk), .reset(reset), .m1s_to_ms_valid(m1s_to_ms_valid),
        .m1s_to_ms_bus(m1s_to_ms_bus), .ms_allowin(ms_allowin), .dcache_rdata(dcache_rdata),
        .ws_valid(ws_valid), .ws_bus(ws_bus), .ws_allowin(ws_allowin)
    );

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #50 clk = ~clk;  // period 100
    end

    initial begin
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- test/tb_cpu_mem1.sv
module tb_cpu_mem1;
    import cpu_pkg::*;

    logic        clk;
    logic        reset;
    logic        es_valid;
    es_to_m1_t   es_bus;
    logic        m1_allowin;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_result;
    logic        fwd_load_op;
    logic        fwd_mfc0;
    logic        flush;
    logic [31:0] flush_target;
    logic [5:0]  ext_int;
    logic        dcache_valid;
    dcache_req_t dcache_req;
    logic        dcache_busy;
    logic [31:0] dcache_rdata;
    logic        ws_valid;
    ws_bus_t     ws_bus;
    logic        ws_allowin;

    string       case_name[64];
    es_to_m1_t   case_bus[64];
    logic [31:0] exp_wdata[64];
    logic        exp_gr_we[64];
    logic        exp_flush[64];
    logic [31:0] exp_target[64];
    logic [19:0] exp_tag[64];
    logic        exp_unc[64];
    int          mem_q[$];         // case index of each expected cache request
    logic [31:0] mem[1024];
    logic [31:0] rdata_next;
    logic [31:0] seed;
    logic        flush_seen;
    logic [31:0] flush_tgt;
    int          n_cases;
    int          retired;
    int          cycles;

    tb_clock_gen clk_gen_i (.clk(clk), .reset(reset));

    cpu_mem1 dut_i (
        .clk(clk), .reset(reset), .es_valid(es_valid), .es_bus(es_bus),
        .m1_allowin(m1_allowin), .fwd_dest(fwd_dest), .fwd_result(fwd_result),
        .fwd_load_op(fwd_load_op), .fwd_mfc0(fwd_mfc0), .flush(flush),
        .flush_target(flush_target), .ext_int(ext_int), .dcache_valid(dcache_valid),
        .dcache_req(dcache_req), .dcache_busy(dcache_busy), .dcache_rdata(dcache_rdata),
        .ws_valid(ws_valid), .ws_bus(ws_bus), .ws_allowin(ws_allowin)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic read_cases();
        int          fd;
        string       line;
        string       name;
        logic [31:0] f[24];
        fd = $fopen("test/mem1_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            $display("TB FAILED");
            $fatal(1, "no case file");
        end
        n_cases = 0;
        while ($fscanf(fd, "%s", name) == 1) begin
            if (name[0] == "#") begin
                void'($fgets(line, fd));  // rest of a comment line
                continue;
            end
            for (int j = 0; j < 24; j++) begin
                void'($fscanf(fd, "%h", f[j]));
            end
            case_name[n_cases] = name;
            case_bus[n_cases]  = '{pc: f[0], alu_result: f[1], rt_value: f[2], dest: f[3][4:0],
                gr_we: f[4][0], load_op: f[5][0], mem_we: f[6][0], wstrb: f[7][3:0],
                wdata: f[8], mem_size: f[9][1:0], load_unsigned: f[10][0],
                inst_mfc0: f[11][0], inst_mtc0: f[12][0], inst_eret: f[13][0],
                cp0_rd: f[14][4:0], cp0_sel: 3'd0, ex: f[15][0], exccode: f[16][4:0],
                bd: f[17][0]};
            exp_wdata[n_cases]  = f[18];
            exp_gr_we[n_cases]  = f[19][0];
            exp_flush[n_cases]  = f[20][0];
            exp_target[n_cases] = f[21];
            exp_tag[n_cases]    = f[22][19:0];
            exp_unc[n_cases]    = f[23][0];
            if ((f[5][0] || f[6][0]) && !f[15][0]) mem_q.push_back(n_cases);
            n_cases++;
        end
        $fclose(fd);
    endtask

    // one cycle of the cache model, stall drivers, monitors and timeout
    always @(negedge clk) begin
        int       k;
        int       a;
        dcache_rdata = rdata_next;  // answer to last cycle's request
        seed         = lcg_next(seed);
        dcache_busy  = (seed[17:16] == 2'b00);
        ws_allowin   = (seed[20:19] != 2'b00);
        cycles++;
        if (cycles > n_cases * 20 + 100) begin
            $display("timeout: the pipeline stopped making progress");
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
        #10;
        if (!reset) begin
            if (flush) begin
                flush_seen = 1'b1;
                flush_tgt  = flush_target;
            end
            if (dcache_valid) begin
                if (mem_q.size() == 0) begin
                    $display("a cache request came with no memory instruction left");
                    $display("TB FAILED");
                    $fatal(1, "extra request");
                end
                k = mem_q.pop_front();
                check_value({case_name[k], " tag"}, exp_tag[k], dcache_req.tag);
                check_value({case_name[k], " uncached"}, exp_unc[k], dcache_req.uncached);
                check_value({case_name[k], " op"}, case_bus[k].mem_we, dcache_req.op);
                check_value({case_name[k], " size"}, case_bus[k].mem_size, dcache_req.size);
                a = {dcache_req.index, dcache_req.offset[3:2]};
                if (dcache_req.op) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dcache_req.wstrb[b]) mem[a][8*b +: 8] = dcache_req.wdata[8*b +: 8];
                    end
                end else begin
                    rdata_next = mem[a];
                end
            end
            if (ws_valid && ws_allowin) begin
                k = retired;
                check_value({case_name[k], " pc"}, case_bus[k].pc, ws_bus.pc);
                check_value({case_name[k], " dest"}, case_bus[k].dest, ws_bus.dest);
                check_value({case_name[k], " gr_we"}, exp_gr_we[k], ws_bus.gr_we);
                check_value({case_name[k], " wdata"}, exp_wdata[k], ws_bus.wdata);
                check_value({case_name[k], " flush"}, exp_flush[k], flush_seen);
                if (exp_flush[k]) check_value({case_name[k], " flush_target"},
                                              exp_target[k], flush_tgt);
                flush_seen = 1'b0;
                retired++;
            end
        end
    end

    initial begin
        logic accepted;
        es_valid     = 1'b0;
        es_bus       = '0;
        ext_int      = 6'h25;
        dcache_busy  = 1'b0;
        dcache_rdata = 32'd0;
        ws_allowin   = 1'b1;
        rdata_next   = 32'd0;
        seed         = 32'd30726;
        flush_seen   = 1'b0;
        retired      = 0;
        cycles       = 0;
        for (int a = 0; a < 1024; a++) mem[a] = {a[9:0], 6'h2a, ~a[9:0], 6'h15};
        read_cases();
        @(negedge reset);
        @(negedge clk);
        for (int i = 0; i < n_cases; i++) begin
            // flushing instructions run alone so the flush is theirs
            while (exp_flush[i] && retired != i) @(negedge clk);
            es_valid = 1'b1;
            es_bus   = case_bus[i];
            accepted = 1'b0;
            while (!accepted) begin
                #10;
                accepted = m1_allowin;
                @(negedge clk);
            end
            es_valid = 1'b0;
            #10;
            check_value({case_name[i], " fwd_dest"}, case_bus[i].dest, fwd_dest);
            check_value({case_name[i], " fwd_load_op"}, case_bus[i].load_op, fwd_load_op);
            check_value({case_name[i], " fwd_mfc0"}, case_bus[i].inst_mfc0, fwd_mfc0);
            if (!case_bus[i].load_op) begin  // load data is not known until ms
                check_value({case_name[i], " fwd_result"}, exp_wdata[i], fwd_result);
            end
            @(negedge clk);
            while (exp_flush[i] && retired != i + 1) @(negedge clk);
        end
        while (retired != n_cases) @(negedge clk);
        check_value("missing cache requests", 32'd0, mem_q.size());
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- test/mem1_cases.txt
# name pc alu rt dest gr_we load mem_we wstrb wdata size uns mfc0 mtc0 eret cp0_rd ex exccode bd
#   then expected: wdata gr_we flush flush_target tag uncached (all hex)
add1 bfc00000 00000011 0 01 1 0 0 0 0 2 0 0 0 0 0 0 0 0 00000011 1 0 0 0 0
add2 bfc00004 12345678 0 02 1 0 0 0 0 2 0 0 0 0 0 0 0 0 12345678 1 0 0 0 0
add3 bfc00008 ffffffff 0 03 1 0 0 0 0 2 0 0 0 0 0 0 0 0 ffffffff 1 0 0 0 0
sw_k0 bfc0000c 80000104 0 00 0 0 1 f 8a7f12c3 2 0 0 0 0 0 0 0 0 80000104 0 0 0 00000 0
lb_k1 bfc00010 a0000107 0 04 1 1 0 0 0 0 0 0 0 0 0 0 0 0 ffffff8a 1 0 0 00000 1
lbu_k0 bfc00014 80000107 0 04 1 1 0 0 0 0 1 0 0 0 0 0 0 0 0000008a 1 0 0 00000 0
lh_k0 bfc00018 80000106 0 04 1 1 0 0 0 1 0 0 0 0 0 0 0 0 ffff8a7f 1 0 0 00000 0
lhu_k0 bfc0001c 80000104 0 04 1 1 0 0 0 1 1 0 0 0 0 0 0 0 000012c3 1 0 0 00000 0
lw_k0 bfc00020 80000104 0 04 1 1 0 0 0 2 0 0 0 0 0 0 0 0 8a7f12c3 1 0 0 00000 0
sw_useg bfc00024 00400010 0 00 0 0 1 f 13579bdf 2 0 0 0 0 0 0 0 0 00400010 0 0 0 20400 0
lw_useg bfc00028 00400010 0 07 1 1 0 0 0 2 0 0 0 0 0 0 0 0 13579bdf 1 0 0 20400 0
mtc0_cmp bfc0002c 0 00001000 00 0 0 0 0 0 2 0 0 1 0 0b 0 0 0 00000000 0 0 0 0 0
mfc0_cmp bfc00030 0 0 05 1 0 0 0 0 2 0 1 0 0 0b 0 0 0 00001000 1 0 0 0 0
mtc0_sts bfc00034 0 0000ff00 00 0 0 0 0 0 2 0 0 1 0 0c 0 0 0 00000000 0 0 0 0 0
mfc0_sts bfc00038 0 0 05 1 0 0 0 0 2 0 1 0 0 0c 0 0 0 0040ff00 1 0 0 0 0
mfc0_cause bfc0003c 0 0 05 1 0 0 0 0 2 0 1 0 0 0d 0 0 0 00009400 1 0 0 0 0
sys bfc00040 0 0 06 1 0 0 0 0 2 0 0 0 0 0 1 08 0 00000000 0 1 bfc00380 0 0
mfc0_epc bfc00380 0 0 05 1 0 0 0 0 2 0 1 0 0 0e 0 0 0 bfc00040 1 0 0 0 0
mfc0_sts2 bfc00384 0 0 05 1 0 0 0 0 2 0 1 0 0 0c 0 0 0 0040ff02 1 0 0 0 0
eret bfc00388 0 0 00 0 0 0 0 0 2 0 0 0 1 0 0 0 0 00000000 0 1 bfc00040 0 0
mfc0_sts3 bfc00040 0 0 05 1 0 0 0 0 2 0 1 0 0 0c 0 0 0 0040ff00 1 0 0 0 0
sys_bd 80001004 0 0 06 1 0 0 0 0 2 0 0 0 0 0 1 08 1 00000000 0 1 bfc00380 0 0
mfc0_epc2 bfc00380 0 0 05 1 0 0 0 0 2 0 1 0 0 0e 0 0 0 80001000 1 0 0 0 0
mfc0_cause2 bfc00384 0 0 05 1 0 0 0 0 2 0 1 0 0 0d 0 0 0 80009420 1 0 0 0 0

//--- cpu_mem1.f
src/cpu_pkg.sv
src/cp0_regs.sv
src/dtlb_map.sv
src/m1_stage.sv
src/ms_stage.sv
src/cpu_mem1.sv
test/tb_clock_gen.sv
test/tb_cpu_mem1.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu_mem1 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_mem1 -Mdir obj_dir -f cpu_mem1.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cpu_mem1 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
